//--- design/osd_bitmap_ram.sv
//####################
// OSD bitmap RAM
// 4096 x 8, registered read
//####################

module osd_bitmap_ram (
	input  logic clk_video,
	input  logic wr_en,
	input  logic [osd_geom_pkg::bitmap_addr_bits-1:0] wr_addr,
	input  logic [7:0] wr_data,
	input  logic [osd_geom_pkg::bitmap_addr_bits-1:0] rd_addr,
	output logic [7:0] rd_data
);

	logic [7:0] mem [osd_geom_pkg::bitmap_depth];

	always_ff @(posedge clk_video) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Read returns the old byte on a same cycle write
	always_ff @(posedge clk_video) begin
		rd_data <= mem[rd_addr];
	end

	// Raster address must settle once reset has been applied
	a_rd_addr_known: assert property (
		@(posedge clk_video)
		##1 !$isunknown(rd_addr)
	);

endmodule

//--- design/osd_blend.sv
//####################
// OSD blender
// Replaces window pixels with the tinted overlay
//####################

module osd_blend (
	input  logic clk_video,
	input  logic rst,
	input  logic [23:0] din,
	input  logic de_in,
	input  logic [7:0] rd_data,
	input  logic [2:0] bit_sel,
	input  logic win_active,
	output logic [23:0] dout,
	output logic de_out
);

	logic [23:0] din_d1;
	logic [23:0] din_d2;
	logic de_d1;
	logic de_d2;
	logic pix;
	logic [23:0] overlay;

	assign pix = rd_data[bit_sel];

	// Glyph bit on top, tint, then a dimmed copy of the input
	assign overlay = {
		pix, pix, osd_geom_pkg::osd_color[2], din_d2[23:19],
		pix, pix, osd_geom_pkg::osd_color[1], din_d2[15:11],
		pix, pix, osd_geom_pkg::osd_color[0], din_d2[7:3]
	};

	always_ff @(posedge clk_video) begin
		din_d1 <= din;
		din_d2 <= din_d1;
		dout <= win_active ? overlay : din_d2;
	end

	always_ff @(posedge clk_video) begin
		if (rst) begin
			de_d1 <= 1'b0;
			de_d2 <= 1'b0;
			de_out <= 1'b0;
		end else begin
			de_d1 <= de_in;
			de_d2 <= de_d1;
			de_out <= de_d2;
		end
	end

	// Raster window flag lines up with the delayed data enable
	a_win_in_de: assert property (
		@(posedge clk_video) disable iff (rst)
		win_active |-> de_d2
	);

endmodule

//--- design/osd_cmd_pkg.sv
//####################
// OSD command package
// Opcodes and command word layout
//####################

package osd_cmd_pkg;

	// Opcodes, first word of a command frame
	localparam logic [7:0] op_enable = 8'h28;
	localparam logic [7:0] op_write = 8'h0c;

	// Parameter words ahead of the bitmap data
	localparam logic [2:0] write_prefix_words = 3'd4;

	typedef struct packed {
		logic [7:0] unused;
		logic [7:0] opcode;
	} cmd_op_t;

	// First parameter of op_enable
	typedef struct packed {
		logic [12:0] unused;
		logic info;
		logic spare;
		logic enable;
	} cmd_ctrl_t;

	typedef union packed {
		cmd_op_t op;
		cmd_ctrl_t ctrl;
	} cmd_word_u;

endpackage

//--- design/osd_cmd_port.sv
//####################
// OSD command port
// Decodes strobed words into bitmap writes and window settings
//####################

module osd_cmd_port (
	input  logic clk_video,
	input  logic rst,
	input  logic io_osd,
	input  logic io_strobe,
	input  logic [15:0] io_din,
	output logic wr_en,
	output logic [osd_geom_pkg::bitmap_addr_bits-1:0] wr_addr,
	output logic [7:0] wr_data,
	output logic osd_enable,
	output logic info,
	output logic [11:0] info_x,
	output logic [11:0] info_y,
	output logic [5:0] info_w,
	output logic [5:0] info_h
);

	osd_cmd_pkg::cmd_word_u word;

	logic strobe_d;
	logic strobe_rise;
	logic has_cmd;
	logic [7:0] cmd;
	logic [2:0] pcnt;
	logic [osd_geom_pkg::bitmap_addr_bits-1:0] bcnt;
	logic en_pending;

	assign word = io_din;
	assign strobe_rise = io_strobe & ~strobe_d;

	always_ff @(posedge clk_video) begin
		if (rst) begin
			strobe_d <= 1'b0;
			has_cmd <= 1'b0;
			cmd <= 8'h00;
			pcnt <= 3'd0;
			bcnt <= '0;
			en_pending <= 1'b0;
			wr_en <= 1'b0;
			osd_enable <= 1'b0;
			info <= 1'b0;
		end else begin
			strobe_d <= io_strobe;
			wr_en <= 1'b0;

			if (!io_osd) begin
				has_cmd <= 1'b0;
				cmd <= 8'h00;
				pcnt <= 3'd0;
				bcnt <= '0;
				// Enable only changes once the frame is closed
				if (cmd == osd_cmd_pkg::op_enable)
					osd_enable <= en_pending;
			end else if (strobe_rise) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd <= word.op.opcode;
					bcnt <= '0;
				end else if (cmd == osd_cmd_pkg::op_write &&
					pcnt < osd_cmd_pkg::write_prefix_words) begin
					pcnt <= pcnt + 3'd1;
					// Last prefix word selects the 256 byte band
					if (pcnt == osd_cmd_pkg::write_prefix_words - 3'd1)
						bcnt <= {io_din[3:0], 8'h00};
				end else begin
					if (cmd == osd_cmd_pkg::op_enable) begin
						case (bcnt)
							12'd0: begin
								en_pending <= word.ctrl.enable;
								info <= word.ctrl.info;
							end
							12'd1: info_x <= io_din[11:0];
							12'd2: info_y <= io_din[11:0];
							12'd3: info_w <= io_din[5:0];
							12'd4: info_h <= io_din[5:0];
							default: ;
						endcase
					end
					if (cmd == osd_cmd_pkg::op_write) begin
						wr_en <= 1'b1;
						wr_addr <= bcnt;
						wr_data <= io_din[7:0];
					end
					bcnt <= bcnt + 1'b1;
				end
			end
		end
	end

	// No bitmap write once the command frame has closed
	a_wr_in_frame: assert property (
		@(posedge clk_video) disable iff (rst)
		wr_en |-> io_osd
	);

endmodule

//--- design/osd_geom_pkg.sv
//####################
// OSD geometry package
// Window size, bitmap depth and tint
//####################

package osd_geom_pkg;

	// Default window size in pixels and lines
	localparam logic [11:0] osd_width = 12'd256;
	localparam logic [11:0] osd_height = 12'd64;

	// Character bitmap, one byte per 8 vertical pixels
	localparam int bitmap_depth = 4096;
	localparam int bitmap_addr_bits = 12;

	// One tint bit per channel, red in bit 2
	localparam logic [2:0] osd_color = 3'd4;

	// Gap longer than this many line widths starts a new frame
	localparam logic [3:0] frame_gap_factor = 4'd4;

endpackage

//--- design/osd_raster.sv
//####################
// OSD raster generator
// Line and frame tracking, window test and bitmap addressing
//####################

module osd_raster (
	input  logic clk_video,
	input  logic rst,
	input  logic de_in,
	input  logic osd_enable,
	input  logic info,
	input  logic [11:0] info_x,
	input  logic [11:0] info_y,
	input  logic [5:0] info_w,
	input  logic [5:0] info_h,
	output logic [osd_geom_pkg::bitmap_addr_bits-1:0] rd_addr,
	output logic [2:0] bit_sel,
	output logic win_active
);

	logic de_d;
	logic [15:0] h_cnt;
	logic [11:0] width;
	logic [11:0] v_line;
	logic [11:0] frame_lines;
	logic en_frame;

	logic rise;
	logic frame_start;
	logic [15:0] gap_limit;
	logic [11:0] h_cur;
	logic [11:0] v_cur;
	logic [11:0] lines_cur;
	logic en_cur;
	logic [11:0] h_start;
	logic [11:0] v_start;
	logic [11:0] win_w;
	logic [11:0] win_h;
	logic [11:0] col;
	logic [11:0] row;
	logic in_win;

	logic [2:0] bit_sel_q;
	logic win_q;

	assign rise = de_in & ~de_d;
	assign gap_limit = 16'(width) * 16'(osd_geom_pkg::frame_gap_factor);
	// h_cnt still holds the previous line period on the rising edge
	assign frame_start = rise && (h_cnt > gap_limit);

	assign h_cur = rise ? 12'd0 : h_cnt[11:0];
	assign v_cur = rise ? (frame_start ? 12'd0 : v_line + 12'd1) : v_line;
	assign lines_cur = frame_start ? v_line + 12'd1 : frame_lines;
	assign en_cur = frame_start ? osd_enable : en_frame;

	// Default window centered on the measured raster
	assign h_start = info ? info_x : (width - osd_geom_pkg::osd_width) >> 1;
	assign v_start = info ? info_y : (lines_cur - osd_geom_pkg::osd_height) >> 1;
	assign win_w = info ? {3'b000, info_w, 3'b000} : osd_geom_pkg::osd_width;
	assign win_h = info ? {3'b000, info_h, 3'b000} : osd_geom_pkg::osd_height;

	assign col = h_cur - h_start;
	assign row = v_cur - v_start;
	assign in_win = en_cur & de_in & (col < win_w) & (row < win_h);

	always_ff @(posedge clk_video) begin
		if (rst) begin
			de_d <= 1'b0;
			h_cnt <= 16'd0;
			width <= 12'd0;
			v_line <= 12'd0;
			frame_lines <= 12'd0;
			en_frame <= 1'b0;
			rd_addr <= '0;
			win_q <= 1'b0;
			win_active <= 1'b0;
		end else begin
			de_d <= de_in;
			if (rise)
				h_cnt <= 16'd1;
			else if (h_cnt != 16'hffff)
				h_cnt <= h_cnt + 16'd1;
			// Active width known on the falling edge
			if (de_d && !de_in)
				width <= h_cnt[11:0];
			if (rise)
				v_line <= v_cur;
			frame_lines <= lines_cur;
			en_frame <= en_cur;

			// Row wraps every 128 lines, column every 256 pixels
			rd_addr <= {row[6:3], col[7:0]};
			win_q <= in_win;
			win_active <= win_q;
		end
	end

	// Bit index follows the RAM read by one cycle
	always_ff @(posedge clk_video) begin
		bit_sel_q <= row[2:0];
		bit_sel <= bit_sel_q;
	end

endmodule

//--- design/osd_top.sv
//####################
// OSD overlay top level
//####################

module osd_top (
	input  logic clk_video,
	input  logic rst,
	input  logic io_osd,
	input  logic io_strobe,
	input  logic [15:0] io_din,
	input  logic [23:0] din,
	input  logic de_in,
	output logic [23:0] dout,
	output logic de_out
);

	logic wr_en;
	logic [osd_geom_pkg::bitmap_addr_bits-1:0] wr_addr;
	logic [7:0] wr_data;
	logic osd_enable;
	logic info;
	logic [11:0] info_x;
	logic [11:0] info_y;
	logic [5:0] info_w;
	logic [5:0] info_h;
	logic [osd_geom_pkg::bitmap_addr_bits-1:0] rd_addr;
	logic [7:0] rd_data;
	logic [2:0] bit_sel;
	logic win_active;

	osd_cmd_port u_cmd_port (
		.clk_video (clk_video),
		.rst (rst),
		.io_osd (io_osd),
		.io_strobe (io_strobe),
		.io_din (io_din),
		.wr_en (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.osd_enable (osd_enable),
		.info (info),
		.info_x (info_x),
		.info_y (info_y),
		.info_w (info_w),
		.info_h (info_h)
	);

	osd_bitmap_ram u_bitmap_ram (
		.clk_video (clk_video),
		.wr_en (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	osd_raster u_raster (
		.clk_video (clk_video),
		.rst (rst),
		.de_in (de_in),
		.osd_enable (osd_enable),
		.info (info),
		.info_x (info_x),
		.info_y (info_y),
		.info_w (info_w),
		.info_h (info_h),
		.rd_addr (rd_addr),
		.bit_sel (bit_sel),
		.win_active (win_active)
	);

	osd_blend u_blend (
		.clk_video (clk_video),
		.rst (rst),
		.din (din),
		.de_in (de_in),
		.rd_data (rd_data),
		.bit_sel (bit_sel),
		.win_active (win_active),
		.dout (dout),
		.de_out (de_out)
	);

endmodule

//--- osd_top.f
design/osd_geom_pkg.sv
design/osd_cmd_pkg.sv
design/osd_cmd_port.sv
design/osd_bitmap_ram.sv
design/osd_raster.sv
design/osd_blend.sv
design/osd_top.sv
tb/osd_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the OSD overlay testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module osd_top_tb \
	-f osd_top.f \
	-o osd_sim

sim_out=$(./obj_dir/osd_sim 2>&1) || true
echo "$sim_out"

if grep -q "Test completed successfully" <<< "$sim_out"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation did not pass"
exit 1

//--- tb/osd_top_tb.sv
//####################
// OSD overlay testbench
// Video source, command driver and pixel model
//####################

module osd_top_tb;

	localparam int h_blank = 40;
	localparam int lines_per_frame = 80;
	localparam int blank_lines = 6;
	localparam int n_cases = 5;
	localparam int frame_max = (300 + h_blank) * (lines_per_frame + blank_lines);
	localparam int cmd_cycles = 2 * (4096 + 4 * 256) + n_cases * 64;
	localparam int timeout_cycles = n_cases * 4 * frame_max + cmd_cycles + 100;

	// One row per case
	string case_name [n_cases] = '{"passthrough", "info_window", "default_window",
		"write_band1", "disable"};
	localparam bit case_en [n_cases] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
	localparam bit case_info [n_cases] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
	localparam logic [11:0] case_x [n_cases] = '{12'd0, 12'd20, 12'd0, 12'd20, 12'd20};
	localparam logic [11:0] case_y [n_cases] = '{12'd0, 12'd10, 12'd0, 12'd10, 12'd10};
	localparam logic [5:0] case_w [n_cases] = '{6'd0, 6'd16, 6'd0, 6'd16, 6'd16};
	localparam logic [5:0] case_h [n_cases] = '{6'd0, 6'd3, 6'd0, 6'd3, 6'd3};
	localparam logic [3:0] case_nibble [n_cases] = '{4'd0, 4'd0, 4'd2, 4'd1, 4'd3};
	localparam int case_count [n_cases] = '{4096, 256, 256, 256, 256};
	localparam int case_line_w [n_cases] = '{200, 200, 300, 200, 200};

	logic clk_video;
	logic rst;
	logic io_osd;
	logic io_strobe;
	logic [15:0] io_din;
	logic [23:0] din;
	logic de_in;
	logic [23:0] dout;
	logic de_out;

	logic [7:0] model_bmp [osd_geom_pkg::bitmap_depth];
	bit en_model = 1'b0;
	bit info_model = 1'b0;
	logic [11:0] x_model = '0;
	logic [11:0] y_model = '0;
	logic [5:0] w_model = '0;
	logic [5:0] h_model = '0;

	logic [31:0] vid_rng = 32'd22910;
	logic [31:0] bmp_rng = 32'd22910;
	int line_w = 200;
	int frame_count = 0;
	int check_frame = -1;
	int cur_case = 0;
	int checked_count = 0;
	int win_count = 0;
	int cycle_count = 0;

	// Expected output for the input pixel driven 3 cycles earlier sits in slot 3
	logic [23:0] exp_dout_p [4];
	logic exp_de_p [4];
	bit chk_p [4] = '{1'b0, 1'b0, 1'b0, 1'b0};

	osd_top UUT (
		.clk_video (clk_video),
		.rst (rst),
		.io_osd (io_osd),
		.io_strobe (io_strobe),
		.io_din (io_din),
		.din (din),
		.de_in (de_in),
		.dout (dout),
		.de_out (de_out)
	);

	initial begin
		clk_video = 1'b0;
		forever #20 clk_video = ~clk_video;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [23:0] expected_pixel(input logic [23:0] pix, input logic active,
		input int h_pos, input int v_pos, input int w);
		logic [11:0] h_start;
		logic [11:0] v_start;
		logic [11:0] win_w;
		logic [11:0] win_h;
		logic [11:0] col;
		logic [11:0] row;
		logic [7:0] byte_val;
		logic b;
		logic [2:0] tint;
		tint = osd_geom_pkg::osd_color;
		if (!en_model || !active)
			return pix;
		if (info_model) begin
			h_start = x_model;
			v_start = y_model;
			win_w = 12'(w_model) * 12'd8;
			win_h = 12'(h_model) * 12'd8;
		end else begin
			h_start = (12'(w) - osd_geom_pkg::osd_width) >> 1;
			v_start = (12'(lines_per_frame) - osd_geom_pkg::osd_height) >> 1;
			win_w = osd_geom_pkg::osd_width;
			win_h = osd_geom_pkg::osd_height;
		end
		col = 12'(h_pos) - h_start;
		row = 12'(v_pos) - v_start;
		if (col >= win_w || row >= win_h)
			return pix;
		// 256 byte bands of 8 rows, bit per row within the byte
		byte_val = model_bmp[{row[6:3], col[7:0]}];
		b = byte_val[row[2:0]];
		return {b, b, tint[2], pix[23:19], b, b, tint[1], pix[15:11], b, b, tint[0], pix[7:3]};
	endfunction

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_value(input string what, input logic [23:0] expected,
		input logic [23:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: %s expected %h actual %h", case_name[cur_case], what,
				expected, actual);
			abort_run();
		end
	endtask

	task automatic send_word(input logic [15:0] value);
		@(posedge clk_video);
		io_din <= value;
		io_strobe <= 1'b1;
		@(posedge clk_video);
		io_strobe <= 1'b0;
	endtask

	task automatic open_frame();
		@(posedge clk_video);
		io_osd <= 1'b1;
	endtask

	task automatic close_frame();
		@(posedge clk_video);
		io_osd <= 1'b0;
		@(posedge clk_video);
	endtask

	task automatic write_bitmap(input logic [3:0] nibble, input int count);
		logic [11:0] addr;
		logic [7:0] data;
		int i;
		addr = {nibble, 8'h00};
		open_frame();
		send_word({8'h00, osd_cmd_pkg::op_write});
		send_word(16'h0000);
		send_word(16'h0000);
		send_word(16'h0000);
		send_word({12'h000, nibble});
		for (i = 0; i < count; i++) begin
			bmp_rng = lcg_next(bmp_rng);
			data = bmp_rng[31:24];
			send_word({8'h00, data});
			model_bmp[addr] = data;
			addr = addr + 12'd1;
		end
		close_frame();
	endtask

	task automatic enable_window(input bit en, input bit inf, input logic [11:0] x,
		input logic [11:0] y, input logic [5:0] w, input logic [5:0] h);
		open_frame();
		send_word({8'h00, osd_cmd_pkg::op_enable});
		send_word({13'd0, inf, 1'b0, en});
		send_word({4'h0, x});
		send_word({4'h0, y});
		send_word({10'd0, w});
		send_word({10'd0, h});
		close_frame();
	endtask

	// Free running raster, line width picked up at each frame start
	initial begin : video_source
		int w;
		int line;
		int px;
		int i;
		logic [23:0] pix;
		logic active;
		logic [23:0] exp_pix;
		while (rst !== 1'b0)
			@(posedge clk_video);
		forever begin
			w = line_w;
			for (line = 0; line < lines_per_frame + blank_lines; line++) begin
				for (px = 0; px < w + h_blank; px++) begin
					@(posedge clk_video);
					if (line == 0 && px == 0)
						frame_count++;
					active = (line < lines_per_frame) && (px < w);
					vid_rng = lcg_next(vid_rng);
					pix = vid_rng[31:8];
					din <= pix;
					de_in <= active;
					exp_pix = expected_pixel(pix, active, px, line, w);
					for (i = 3; i > 0; i--) begin
						exp_dout_p[i] = exp_dout_p[i-1];
						exp_de_p[i] = exp_de_p[i-1];
						chk_p[i] = chk_p[i-1];
					end
					exp_dout_p[0] = exp_pix;
					exp_de_p[0] = active;
					chk_p[0] = (frame_count == check_frame);
					if (chk_p[0] && exp_pix !== pix)
						win_count++;
				end
			end
		end
	end

	always @(negedge clk_video) begin
		if (chk_p[3]) begin
			compare_value("de_out", 24'(exp_de_p[3]), 24'(de_out));
			compare_value("dout", exp_dout_p[3], dout);
			checked_count++;
		end
	end

	always @(posedge clk_video) begin
		cycle_count++;
		if (cycle_count > timeout_cycles) begin
			$display("Timeout: no result after %0d clock cycles", timeout_cycles);
			abort_run();
		end
	end

	initial begin : main_sequence
		int c;
		int f0;
		rst = 1'b1;
		io_osd = 1'b0;
		io_strobe = 1'b0;
		io_din = 16'h0000;
		din = 24'h000000;
		de_in = 1'b0;
		repeat (5) @(posedge clk_video);
		rst <= 1'b0;

		for (c = 0; c < n_cases; c++) begin
			cur_case = c;
			line_w = case_line_w[c];
			checked_count = 0;
			win_count = 0;
			write_bitmap(case_nibble[c], case_count[c]);
			enable_window(case_en[c], case_info[c], case_x[c], case_y[c], case_w[c], case_h[c]);
			en_model = case_en[c];
			info_model = case_info[c];
			x_model = case_x[c];
			y_model = case_y[c];
			w_model = case_w[c];
			h_model = case_h[c];

			// One settling frame, then one checked frame
			repeat (4) @(posedge clk_video);
			f0 = frame_count;
			check_frame = f0 + 2;
			wait (frame_count == f0 + 3);
			repeat (4) @(posedge clk_video);

			if (checked_count != (line_w + h_blank) * (lines_per_frame + blank_lines)) begin
				$display("Case %s checked %0d pixels instead of a full frame",
					case_name[c], checked_count);
				abort_run();
			end
			if (case_en[c] && win_count == 0) begin
				$display("Case %s saw no window pixels in the checked frame", case_name[c]);
				abort_run();
			end
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule
